//--- design/block_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module block_sequencer
	import dsp_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        tick,
	input  logic        command_instr_write,
	input  block_addr_t command_block_target,
	input  instr_t      command_instr_write_val,
	input  logic        commit,
	output logic        frame_start,
	output logic        issue,
	output logic        busy,
	output block_addr_t block,
	output chan_addr_t  src_a,
	output chan_addr_t  src_b,
	output chan_addr_t  src_c,
	output chan_addr_t  dest,
	output logic        a_reg,
	output logic        b_reg,
	output logic        c_reg,
	output logic        saturate_disable,
	output shift_t      shift
);
	instr_t       instrs [N_BLOCKS];
	instr_t       instr_word;
	block_count_t block_count;
	seq_state_t   state;
	logic         last_block;

	assign busy       = (state != IDLE);
	assign last_block = (block_count_t'(block) + 1'b1) == block_count;

	always_ff @(posedge clk) begin
		if (command_instr_write) begin
			instrs[command_block_target] <= command_instr_write_val;
		end
	end

	// Count only grows, so rewriting a lower block keeps the program length
	always_ff @(posedge clk) begin
		if (reset) begin
			block_count <= '0;
		end else if (command_instr_write &&
				block_count_t'(command_block_target) >= block_count) begin
			block_count <= block_count_t'(command_block_target) + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			block       <= '0;
			frame_start <= 1'b0;
			issue       <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			issue       <= 1'b0;
			case (state)
				IDLE: begin
					if (tick) begin
						frame_start <= 1'b1;
						block       <= '0;
						if (block_count != '0) begin
							state <= FETCH;
						end
					end
				end
				FETCH: begin
					issue <= 1'b1;
					state <= WAIT;
				end
				WAIT: begin
					// One block in flight, so the next fetch waits for this commit
					if (commit) begin
						if (last_block) begin
							state <= IDLE;
						end else begin
							block <= block + 1'b1;
							state <= FETCH;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH) begin
			instr_word <= instrs[block];
		end
	end

	// Fields stay put until the next fetch
	assign dest             = instr_word[DEST_LSB +: CHAN_W];
	assign src_a            = instr_word[SRC_A_LSB +: CHAN_W];
	assign src_b            = instr_word[SRC_B_LSB +: CHAN_W];
	assign src_c            = instr_word[SRC_C_LSB +: CHAN_W];
	assign a_reg            = instr_word[A_REG_BIT];
	assign b_reg            = instr_word[B_REG_BIT];
	assign c_reg            = instr_word[C_REG_BIT];
	assign shift            = instr_word[SHIFT_LSB +: SHIFT_W];
	assign saturate_disable = instr_word[SAT_DIS_BIT];

endmodule

`default_nettype wire

//--- design/channel_file.sv
`timescale 1ns/1ns
`default_nettype none

module channel_file
	import dsp_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       frame_start,
	input  sample_t    sample_in,
	input  chan_addr_t src_a,
	input  chan_addr_t src_b,
	input  chan_addr_t src_c,
	input  logic       commit,
	input  chan_addr_t dest,
	input  sample_t    result,
	output sample_t    chan_a,
	output sample_t    chan_b,
	output sample_t    chan_c,
	output sample_t    sample_out
);
	sample_t chans [N_CHANNELS];

	assign chan_a = chans[src_a];
	assign chan_b = chans[src_b];
	assign chan_c = chans[src_c];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_CHANNELS; i++) begin
				chans[i] <= '0;
			end
			sample_out <= '0;
		end else begin
			// Output carries what the previous frame left behind
			if (frame_start) begin
				chans[IN_CHANNEL] <= sample_in;
				sample_out        <= chans[OUT_CHANNEL];
			end
			if (commit) begin
				chans[dest] <= result;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/dsp_core.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_core
	import dsp_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        tick,
	input  sample_t     sample_in,
	output sample_t     sample_out,
	output logic        busy,
	input  logic        command_instr_write,
	input  logic        command_reg_write,
	input  block_addr_t command_block_target,
	input  logic        command_reg_target,
	input  instr_t      command_instr_write_val,
	input  sample_t     command_reg_write_val
);
	logic        frame_start;
	logic        issue;
	block_addr_t block;
	chan_addr_t  src_a;
	chan_addr_t  src_b;
	chan_addr_t  src_c;
	chan_addr_t  dest;
	logic        a_reg;
	logic        b_reg;
	logic        c_reg;
	logic        saturate_disable;
	shift_t      shift;
	sample_t     chan_a;
	sample_t     chan_b;
	sample_t     chan_c;
	logic        operands_valid;
	sample_t     a;
	sample_t     b;
	sample_t     c;
	logic        commit;
	chan_addr_t  commit_dest;
	sample_t     result;

	block_sequencer sequencer (
		.clk                     (clk),
		.reset                   (reset),
		.tick                    (tick),
		.command_instr_write     (command_instr_write),
		.command_block_target    (command_block_target),
		.command_instr_write_val (command_instr_write_val),
		.commit                  (commit),
		.frame_start             (frame_start),
		.issue                   (issue),
		.busy                    (busy),
		.block                   (block),
		.src_a                   (src_a),
		.src_b                   (src_b),
		.src_c                   (src_c),
		.dest                    (dest),
		.a_reg                   (a_reg),
		.b_reg                   (b_reg),
		.c_reg                   (c_reg),
		.saturate_disable        (saturate_disable),
		.shift                   (shift)
	);

	operand_fetch fetch (
		.clk                   (clk),
		.reset                 (reset),
		.issue                 (issue),
		.block                 (block),
		.src_a                 (src_a),
		.src_b                 (src_b),
		.src_c                 (src_c),
		.a_reg                 (a_reg),
		.b_reg                 (b_reg),
		.c_reg                 (c_reg),
		.chan_a                (chan_a),
		.chan_b                (chan_b),
		.chan_c                (chan_c),
		.command_reg_write     (command_reg_write),
		.command_block_target  (command_block_target),
		.command_reg_target    (command_reg_target),
		.command_reg_write_val (command_reg_write_val),
		.operands_valid        (operands_valid),
		.a                     (a),
		.b                     (b),
		.c                     (c)
	);

	madd_unit madd (
		.clk              (clk),
		.reset            (reset),
		.operands_valid   (operands_valid),
		.a                (a),
		.b                (b),
		.c                (c),
		.shift            (shift),
		.saturate_disable (saturate_disable),
		.dest_in          (dest),
		.commit           (commit),
		.dest             (commit_dest),
		.result           (result)
	);

	channel_file channels (
		.clk         (clk),
		.reset       (reset),
		.frame_start (frame_start),
		.sample_in   (sample_in),
		.src_a       (src_a),
		.src_b       (src_b),
		.src_c       (src_c),
		.commit      (commit),
		.dest        (commit_dest),
		.result      (result),
		.chan_a      (chan_a),
		.chan_b      (chan_b),
		.chan_c      (chan_c),
		.sample_out  (sample_out)
	);

endmodule

`default_nettype wire

//--- design/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	localparam int DATA_W     = 16;
	localparam int PRODUCT_W  = 2 * DATA_W;
	localparam int INSTR_W    = 32;
	localparam int N_BLOCKS   = 16;
	localparam int N_CHANNELS = 16;
	localparam int SHIFT_W    = 5;
	localparam int CHAN_W     = $clog2(N_CHANNELS);

	// Instruction word layout, bits 31 to 25 are ignored
	localparam int DEST_LSB    = 0;
	localparam int SRC_A_LSB   = 4;
	localparam int SRC_B_LSB   = 8;
	localparam int SRC_C_LSB   = 12;
	localparam int A_REG_BIT   = 16;
	localparam int B_REG_BIT   = 17;
	localparam int C_REG_BIT   = 18;
	localparam int SHIFT_LSB   = 19;
	localparam int SAT_DIS_BIT = 24;

	typedef logic signed [DATA_W-1:0]    sample_t;
	typedef logic signed [PRODUCT_W-1:0] product_t;
	typedef logic [INSTR_W-1:0]          instr_t;
	typedef logic [$clog2(N_BLOCKS)-1:0] block_addr_t;
	typedef logic [$clog2(N_BLOCKS):0]   block_count_t;
	typedef logic [CHAN_W-1:0]           chan_addr_t;
	typedef logic [SHIFT_W-1:0]          shift_t;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		WAIT
	} seq_state_t;

	localparam chan_addr_t IN_CHANNEL  = 4'd0;
	localparam chan_addr_t OUT_CHANNEL = 4'd1;

	// Clamp limits of the result
	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage

`default_nettype wire

//--- design/madd_unit.sv
`timescale 1ns/1ns
`default_nettype none

module madd_unit
	import dsp_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       operands_valid,
	input  sample_t    a,
	input  sample_t    b,
	input  sample_t    c,
	input  shift_t     shift,
	input  logic       saturate_disable,
	input  chan_addr_t dest_in,
	output logic       commit,
	output chan_addr_t dest,
	output sample_t    result
);
	product_t                   product_q;
	sample_t                    c_q;
	logic                       valid_q;
	product_t                   shifted;
	logic signed [PRODUCT_W:0]  sum;
	sample_t                    next_result;

	always_ff @(posedge clk) begin
		if (operands_valid) begin
			product_q <= product_t'(a) * product_t'(b);
			c_q       <= c;
		end
	end

	// One spare bit keeps the sum from overflowing before the clamp
	always_comb begin
		shifted = product_q >>> shift;
		sum     = {shifted[PRODUCT_W-1], shifted} +
			{{(PRODUCT_W + 1 - DATA_W){c_q[DATA_W-1]}}, c_q};
		if (saturate_disable) begin
			next_result = sum[DATA_W-1:0];
		end else if (sum > SAMPLE_MAX) begin
			next_result = SAMPLE_MAX;
		end else if (sum < SAMPLE_MIN) begin
			next_result = SAMPLE_MIN;
		end else begin
			next_result = sum[DATA_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (valid_q) begin
			result <= next_result;
			dest   <= dest_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
			commit  <= 1'b0;
		end else begin
			valid_q <= operands_valid;
			commit  <= valid_q;
		end
	end

endmodule

`default_nettype wire

//--- design/operand_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch
	import dsp_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        issue,
	input  block_addr_t block,
	input  chan_addr_t  src_a,
	input  chan_addr_t  src_b,
	input  chan_addr_t  src_c,
	input  logic        a_reg,
	input  logic        b_reg,
	input  logic        c_reg,
	input  sample_t     chan_a,
	input  sample_t     chan_b,
	input  sample_t     chan_c,
	input  logic        command_reg_write,
	input  block_addr_t command_block_target,
	input  logic        command_reg_target,
	input  sample_t     command_reg_write_val,
	output logic        operands_valid,
	output sample_t     a,
	output sample_t     b,
	output sample_t     c
);
	sample_t regs [N_BLOCKS][2];
	sample_t reg0;
	sample_t reg1;

	assign reg0 = regs[block][0];
	assign reg1 = regs[block][1];

	// Low bit of the source field picks the block register
	function automatic sample_t select_operand(
		input logic       use_reg,
		input chan_addr_t src,
		input sample_t    chan_val,
		input sample_t    r0,
		input sample_t    r1
	);
		if (!use_reg) begin
			return chan_val;
		end
		return src[0] ? r1 : r0;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_BLOCKS; i++) begin
				regs[i][0] <= '0;
				regs[i][1] <= '0;
			end
		end else if (command_reg_write) begin
			regs[command_block_target][command_reg_target] <= command_reg_write_val;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			operands_valid <= 1'b0;
		end else begin
			operands_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			a <= select_operand(a_reg, src_a, chan_a, reg0, reg1);
			b <= select_operand(b_reg, src_b, chan_b, reg0, reg1);
			c <= select_operand(c_reg, src_c, chan_c, reg0, reg1);
		end
	end

endmodule

`default_nettype wire

//--- dsp_core.f
design/dsp_pkg.sv
design/channel_file.sv
design/madd_unit.sv
design/operand_fetch.sv
design/block_sequencer.sv
design/dsp_core.sv
tests/dsp_core_assert.sv
tests/dsp_core_checker.sv
tests/dsp_core_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module dsp_core_tb -f dsp_core.f -o dsp_core_sim &&
./obj_dir/dsp_core_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log 2>/dev/null && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tests/dsp_core_assert.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_core_assert (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic commit,
	input logic frame_start
);
	int failures = 0;

	commit_in_frame: assert property (@(posedge clk) disable iff (reset) commit |-> busy)
	else begin
		$error("commit pulsed while no frame was running");
		failures++;
	end

	// A frame can only start from idle
	frame_from_idle: assert property (@(posedge clk) disable iff (reset)
		frame_start |-> !$past(busy))
	else begin
		$error("frame_start pulsed although the core was busy");
		failures++;
	end

	quiet_after_reset: assert property (@(posedge clk) reset |=> (!busy && !commit))
	else begin
		$error("busy or commit high in the cycle after reset");
		failures++;
	end

endmodule

`default_nettype wire

//--- tests/dsp_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_core_checker
	import dsp_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    busy,
	input  sample_t sample_out,
	output int      checks,
	output int      errors
);
	sample_t last_out;
	logic    last_busy;
	logic    older_busy;

	initial begin
		checks     = 0;
		errors     = 0;
		last_out   = '0;
		last_busy  = 1'b0;
		older_busy = 1'b0;
	end

	task automatic expect_sample(input string name, input sample_t expected);
		checks++;
		if (sample_out !== expected) begin
			errors++;
			$display("Fail %s: expected %0d, actual %0d", name, expected, sample_out);
		end
	endtask

	task automatic expect_idle(input string name);
		checks++;
		if (busy !== 1'b0) begin
			errors++;
			$display("%s: busy went high although no block is loaded", name);
		end
	endtask

	// sample_out may only move on the edge right after a frame starts
	always @(negedge clk) begin
		if (!reset && older_busy && last_busy && (sample_out !== last_out)) begin
			errors++;
			$display("sample_out changed while a frame was still running");
		end
		last_out   = sample_out;
		older_busy = last_busy;
		last_busy  = busy;
	end

endmodule

`default_nettype wire

//--- tests/dsp_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_core_tb
	import dsp_pkg::*;
();
	localparam int N_ROWS         = 11;
	localparam int MAX_WORDS      = 4;
	localparam int FRAME_LIMIT    = N_BLOCKS * 5 + 10;
	localparam int TIMEOUT_CYCLES = N_ROWS * 2 * FRAME_LIMIT + 50;

	logic        clk = 1'b0;
	logic        reset;
	logic        tick;
	sample_t     sample_in;
	sample_t     sample_out;
	logic        busy;
	logic        command_instr_write;
	logic        command_reg_write;
	block_addr_t command_block_target;
	logic        command_reg_target;
	instr_t      command_instr_write_val;
	sample_t     command_reg_write_val;
	int          checks;
	int          errors;

	string   row_name  [N_ROWS];
	int      row_words [N_ROWS];
	instr_t  row_prog  [N_ROWS][MAX_WORDS];
	sample_t row_regs  [N_ROWS][4];
	sample_t row_in    [N_ROWS];
	sample_t row_out   [N_ROWS];

	dsp_core uut (
		.clk                     (clk),
		.reset                   (reset),
		.tick                    (tick),
		.sample_in               (sample_in),
		.sample_out              (sample_out),
		.busy                    (busy),
		.command_instr_write     (command_instr_write),
		.command_reg_write       (command_reg_write),
		.command_block_target    (command_block_target),
		.command_reg_target      (command_reg_target),
		.command_instr_write_val (command_instr_write_val),
		.command_reg_write_val   (command_reg_write_val)
	);

	dsp_core_checker check (
		.clk        (clk),
		.reset      (reset),
		.busy       (busy),
		.sample_out (sample_out),
		.checks     (checks),
		.errors     (errors)
	);

	bind dsp_core dsp_core_assert assertions (
		.clk         (clk),
		.reset       (reset),
		.busy        (busy),
		.commit      (commit),
		.frame_start (frame_start)
	);

	always #50 clk = ~clk;

	// reg_flags is {c_reg, b_reg, a_reg}
	function automatic instr_t make_instr(input int dest, input int src_a, input int src_b,
			input int src_c, input logic [2:0] reg_flags, input int shift, input logic wrap);
		return {7'd0, wrap, 5'(shift), reg_flags, 4'(src_c), 4'(src_b), 4'(src_a), 4'(dest)};
	endfunction

	task automatic step_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic set_row(input int idx, input string name, input int words,
			input instr_t first, input instr_t second,
			input sample_t b0r0, input sample_t b0r1, input sample_t b1r0, input sample_t b1r1,
			input sample_t in_value, input sample_t out_value);
		row_name[idx]    = name;
		row_words[idx]   = words;
		row_prog[idx][0] = first;
		row_prog[idx][1] = second;
		row_prog[idx][2] = '0;
		row_prog[idx][3] = '0;
		row_regs[idx][0] = b0r0;
		row_regs[idx][1] = b0r1;
		row_regs[idx][2] = b1r0;
		row_regs[idx][3] = b1r1;
		row_in[idx]      = in_value;
		row_out[idx]     = out_value;
	endtask

	task automatic fill_table();
		instr_t pass_word;
		instr_t scale_word;
		instr_t wrap_word;
		instr_t chain_first;
		instr_t chain_second;
		instr_t halve_word;
		pass_word    = make_instr(1, 0, 0, 1, 3'b110, 0, 1'b0);
		scale_word   = make_instr(1, 0, 0, 1, 3'b110, 15, 1'b0);
		wrap_word    = make_instr(1, 0, 0, 1, 3'b110, 0, 1'b1);
		chain_first  = make_instr(5, 0, 0, 1, 3'b110, 0, 1'b0);
		chain_second = make_instr(1, 5, 0, 1, 3'b110, 0, 1'b0);
		halve_word   = make_instr(5, 0, 0, 1, 3'b110, 1, 1'b0);
		set_row(0, "pass_through", 1, pass_word, '0, 16'sd1, 16'sd0, 16'sd0, 16'sd0,
			16'sh1234, 16'sh1234);
		set_row(1, "pass_negative", 1, pass_word, '0, 16'sd1, 16'sd0, 16'sd0, 16'sd0,
			-16'sd12345, -16'sd12345);
		// 1000 * 0x4000 >>> 15 is 500
		set_row(2, "scale_offset", 1, scale_word, '0, 16'sh4000, 16'sd100, 16'sd0, 16'sd0,
			16'sd1000, 16'sd600);
		// -500.5 rounds down to -501 under the arithmetic shift
		set_row(3, "scale_negative", 1, scale_word, '0, 16'sh4000, -16'sd7, 16'sd0, 16'sd0,
			-16'sd1001, -16'sd508);
		set_row(4, "clamp_positive", 1, pass_word, '0, 16'sd32767, 16'sd0, 16'sd0, 16'sd0,
			16'sd32767, 16'sd32767);
		set_row(5, "clamp_negative", 1, pass_word, '0, 16'sd32767, 16'sd0, 16'sd0, 16'sd0,
			-16'sd32767, 16'sh8000);
		// 0x3fff0001 and 0xc000ffff keep only their low halves
		set_row(6, "wrap_positive", 1, wrap_word, '0, 16'sd32767, 16'sd0, 16'sd0, 16'sd0,
			16'sd32767, 16'sd1);
		set_row(7, "wrap_negative", 1, wrap_word, '0, 16'sd32767, 16'sd0, 16'sd0, 16'sd0,
			-16'sd32767, -16'sd1);
		// Channel 5 gets 2*in+3, then channel 1 gets b1r0*ch5-10
		set_row(8, "chain", 2, chain_first, chain_second, 16'sd2, 16'sd3, 16'sd3, -16'sd10,
			16'sd100, 16'sd599);
		set_row(9, "reprog_register", 2, chain_first, chain_second,
			16'sd2, 16'sd3, 16'sd5, -16'sd10, 16'sd100, 16'sd1005);
		// Only block 0 rewritten, block 1 still runs
		set_row(10, "reprog_lower_block", 1, halve_word, '0, 16'sd4, 16'sd0, 16'sd5, -16'sd10,
			-16'sd50, -16'sd510);
	endtask

	task automatic write_instr(input block_addr_t target, input instr_t word);
		command_instr_write     = 1'b1;
		command_block_target    = target;
		command_instr_write_val = word;
		step_cycle();
		command_instr_write     = 1'b0;
	endtask

	task automatic write_reg(input block_addr_t target, input logic which, input sample_t value);
		command_reg_write     = 1'b1;
		command_block_target  = target;
		command_reg_target    = which;
		command_reg_write_val = value;
		step_cycle();
		command_reg_write     = 1'b0;
	endtask

	task automatic run_frame(input sample_t value);
		sample_in = value;
		tick      = 1'b1;
		step_cycle();
		// tick stays high through the frame and must be ignored while busy
		while (busy) begin
			step_cycle();
		end
		tick      = 1'b0;
	endtask

	task automatic run_row(input int idx);
		for (int w = 0; w < row_words[idx]; w++) begin
			write_instr(block_addr_t'(w), row_prog[idx][w]);
		end
		for (int r = 0; r < 4; r++) begin
			write_reg(block_addr_t'(r / 2), 1'(r % 2), row_regs[idx][r]);
		end
		run_frame(row_in[idx]);
		run_frame(sample_t'($urandom()));
		check.expect_sample(row_name[idx], row_out[idx]);
	endtask

	initial begin
		void'($urandom(32'hd9b7aa0e));
		reset                   = 1'b1;
		tick                    = 1'b0;
		sample_in               = '0;
		command_instr_write     = 1'b0;
		command_reg_write       = 1'b0;
		command_block_target    = '0;
		command_reg_target      = 1'b0;
		command_instr_write_val = '0;
		command_reg_write_val   = '0;
		fill_table();
		repeat (3) @(posedge clk);
		#10;
		reset = 1'b0;
		check.expect_sample("reset_output", 16'sd0);
		// Empty program, so the tick must not start a walk
		sample_in = 16'sh0abc;
		tick      = 1'b1;
		step_cycle();
		tick      = 1'b0;
		check.expect_idle("tick_without_program");
		run_frame(16'sh0def);
		check.expect_sample("output_without_program", 16'sd0);
		for (int i = 0; i < N_ROWS; i++) begin
			run_row(i);
		end
		step_cycle();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, uut.assertions.failures);
		if (errors == 0 && uut.assertions.failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Run timed out after %0d cycles before the table was finished", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
